// File: rtl/decode_settings.svh
// Build-time constants for the instruction decode stage
// Included by the instruction queue and the top level
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// ==========================================================
// Instruction queue
// ==========================================================
// Words held before back-pressure reaches the host, power of two
`define QUEUE_DEPTH 8

// ==========================================================
// APB register map
// ==========================================================
`define APB_ADDR_W 4
// Write only, pushes one instruction word
`define REG_INSTR 4'h0
// Read only, fill level and prefix state
`define REG_STATUS 4'h4

`endif

// File: rtl/decodePkg.sv
// Instruction formats, opcode tables and the decode record
// Shared by every module of the decode stage and by the testbench
`default_nettype none

package decodePkg;

	// ==========================================================
	// Opcodes and R2 function codes
	// ==========================================================
	typedef enum logic [5:0] {
		NOP = 6'h00, R2 = 6'h02,
		ADDI = 6'h04, ANDI = 6'h05, ORI = 6'h06, XORI = 6'h07,
		MULI = 6'h08, MULUI = 6'h09, DIVI = 6'h0A,
		LDB = 6'h10, LDBU = 6'h11, LDW = 6'h12, LDWU = 6'h13, LDT = 6'h14,
		STB = 6'h18, STW = 6'h19, STT = 6'h1A,
		JMP = 6'h20, JEQ = 6'h24, JNE = 6'h25, JLT = 6'h26, JGE = 6'h27,
		EXI = 6'h3F
	} opcodeE;

	typedef enum logic [5:0] {
		ADD = 6'h00, SUB = 6'h01, AND = 6'h02, OR = 6'h03,
		MUL = 6'h08, MULU = 6'h09, DIV = 6'h0C, DIVU = 6'h0D
	} funcE;

	typedef enum logic [1:0] {byt = 2'd0, wyde = 2'd1, tetra = 2'd2} memSizeE;

	// ==========================================================
	// Instruction formats, opcode always in bits 31:26
	// ==========================================================
	typedef struct packed {opcodeE opcode; logic [4:0] Rt; logic [4:0] Ra; logic [4:0] Rb;
		logic [4:0] pad; funcE func;} r2FormatT;
	typedef struct packed {opcodeE opcode; logic [4:0] Rt; logic [4:0] Ra;
		logic [15:0] imm16;} riFormatT;
	// RtRs is the target for loads and the data source for stores
	typedef struct packed {opcodeE opcode; logic [4:0] RtRs; logic [4:0] Ra;
		logic [15:0] disp16;} memFormatT;
	typedef struct packed {opcodeE opcode; logic [4:0] Ra; logic [4:0] Rb;
		logic [4:0] pad; logic [10:0] disp11;} jxxFormatT;
	typedef struct packed {opcodeE opcode; logic [25:0] tgt26;} jmpFormatT;
	typedef struct packed {opcodeE opcode; logic [9:0] pad; logic [15:0] hi16;} exiFormatT;

	typedef union packed {
		r2FormatT r2;
		riFormatT ri;
		memFormatT mem;
		jxxFormatT jxx;
		jmpFormatT jmp;
		exiFormatT exi;
	} instrT;

	// Instruction plus the prefix that preceded it
	typedef struct packed {instrT ir; instrT xir; logic prefixed;} instrPairT;

	// ==========================================================
	// Decode record handed to issue
	// ==========================================================
	typedef struct packed {
		logic [4:0] Ra;
		logic [4:0] Rb;
		logic [4:0] Rc;
		logic [4:0] Rt;
		logic rfwr;
		logic [31:0] imm;
		logic ld;
		logic ldz;
		logic st;
		memSizeE memsz;
		logic mul;
		logic mulu;
		logic div;
		logic divu;
		logic multiCycle;
		logic jmp;
		logic jxx;
		logic [31:0] jmptgt;
		logic prefixed;
	} decodeOutT;

endpackage

`default_nettype wire

// File: rtl/instrQueue.sv
// APB slave that loads instruction words into a circular FIFO
// The oldest word sits at the head, a status read reports the fill level
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module instrQueue
(
	input  logic clk,
	input  logic rstN,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic headValid,
	output decodePkg::instrT headInstr,
	input  logic headPop,
	input  logic prefixHeld
);

localparam int PTR_W = $clog2(`QUEUE_DEPTH);
localparam int CNT_W = PTR_W + 1;

decodePkg::instrT mem [`QUEUE_DEPTH];
logic [PTR_W-1:0] wrPtr;
logic [PTR_W-1:0] rdPtr;
logic [CNT_W-1:0] count;
logic access;
logic instrSel;
logic statusSel;
logic full;
logic push;

// ==========================================================
// APB decoding
// ==========================================================
assign access = psel && penable;
assign instrSel = paddr == `REG_INSTR;
assign statusSel = paddr == `REG_STATUS;
assign full = count == CNT_W'(`QUEUE_DEPTH);
assign push = access && pwrite && instrSel && !full;

// No wait states
assign pready = 1'b1;

// Overflow drops the word, status is read only
assign pslverr = access && ((pwrite && instrSel && full)
	|| (pwrite && statusSel)
	|| (!instrSel && !statusSel));

assign prdata = (psel && !pwrite && statusSel)
	? {23'd0, prefixHeld, 4'd0, 4'(count)}
	: 32'd0;

// ==========================================================
// FIFO storage
// ==========================================================
always_ff @(posedge clk)
begin
	if (push)
		mem[wrPtr] <= pwdata;
end

always_ff @(posedge clk)
begin
	if (!rstN)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
	end
	else
	begin
		if (push)
			wrPtr <= wrPtr + 1'b1;
		if (headPop)
			rdPtr <= rdPtr + 1'b1;
		case ({push, headPop})
		2'b10:	count <= count + 1'b1;
		2'b01:	count <= count - 1'b1;
		default:	count <= count;
		endcase
	end
end

assign headValid = count != '0;
assign headInstr = mem[rdPtr];

// The merger only pops what is there
assert property (@(posedge clk) disable iff (!rstN) headPop |-> headValid)
	else $error("headPop with empty queue");
assert property (@(posedge clk) disable iff (!rstN) count <= CNT_W'(`QUEUE_DEPTH))
	else $error("queue count above depth");

endmodule

`default_nettype wire

// File: rtl/prefixMerge.sv
// Holds an EXI prefix and attaches it to the next instruction
// Prefix words are consumed here and never reach issue on their own
`default_nettype none
`timescale 1ns/100ps

module prefixMerge
(
	input  logic clk,
	input  logic rstN,
	input  logic headValid,
	input  decodePkg::instrT headInstr,
	input  logic pairReady,
	output logic headPop,
	output logic pairValid,
	output decodePkg::instrPairT pair,
	output logic prefixHeld
);

decodePkg::instrT heldXir;
logic headIsExi;

assign headIsExi = headInstr.exi.opcode == decodePkg::EXI;

// A prefix is swallowed in one cycle, anything else waits for the stage
assign pairValid = headValid && !headIsExi;
assign headPop = headValid && (headIsExi || pairReady);

always_comb
begin
	pair.ir = headInstr;
	pair.prefixed = prefixHeld;
	if (prefixHeld)
		pair.xir = heldXir;
	else
		pair.xir = '0;
end

always_ff @(posedge clk)
begin
	if (!rstN)
		prefixHeld <= 1'b0;
	else if (headValid && headIsExi)
		prefixHeld <= 1'b1;
	else if (pairValid && pairReady)
		prefixHeld <= 1'b0;
end

// Back to back prefixes keep only the newest one
always_ff @(posedge clk)
begin
	if (headValid && headIsExi)
		heldXir <= headInstr;
end

assert property (@(posedge clk) disable iff (!rstN)
	pairValid && !pairReady |=> pairValid && $stable(pair))
	else $error("pair changed while stalled");

endmodule

`default_nettype wire

// File: rtl/instrDecoder.sv
// Combinational decoder from an instruction pair to a decode record
// One case per record field, prefix bits override the upper immediate
`default_nettype none
`timescale 1ns/100ps

module instrDecoder
(
	input  decodePkg::instrPairT pair,
	output decodePkg::decodeOutT deco
);

decodePkg::instrT ir;
decodePkg::opcodeE op;
logic [31:0] imm;
logic hasImm;

assign ir = pair.ir;
assign op = pair.ir.r2.opcode;

always_comb
begin
	// ==========================================================
	// Register fields
	// ==========================================================
	// Branches carry both sources in the upper fields
	case (op)
	decodePkg::JEQ, decodePkg::JNE, decodePkg::JLT, decodePkg::JGE:
		begin
			deco.Ra = ir.jxx.Ra;
			deco.Rb = ir.jxx.Rb;
		end
	default:
		begin
			deco.Ra = ir.r2.Ra;
			deco.Rb = ir.r2.Rb;
		end
	endcase

	case (op)
	decodePkg::STB, decodePkg::STW, decodePkg::STT,
	decodePkg::JMP, decodePkg::JEQ, decodePkg::JNE, decodePkg::JLT, decodePkg::JGE:
		deco.Rt = 5'd0;
	default:	deco.Rt = ir.r2.Rt;
	endcase

	// Store data comes in on the third read port
	case (op)
	decodePkg::STB, decodePkg::STW, decodePkg::STT:	deco.Rc = ir.mem.RtRs;
	default:	deco.Rc = 5'd0;
	endcase

	case (op)
	decodePkg::R2,
	decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI, decodePkg::XORI,
	decodePkg::MULI, decodePkg::MULUI, decodePkg::DIVI,
	decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU, decodePkg::LDT:
		deco.rfwr = 1'b1;
	default:	deco.rfwr = 1'b0;
	endcase

	// ==========================================================
	// Memory access
	// ==========================================================
	case (op)
	decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU, decodePkg::LDT:
		deco.ld = 1'b1;
	default:	deco.ld = 1'b0;
	endcase

	case (op)
	decodePkg::LDBU, decodePkg::LDWU:	deco.ldz = 1'b1;
	default:	deco.ldz = 1'b0;
	endcase

	case (op)
	decodePkg::STB, decodePkg::STW, decodePkg::STT:	deco.st = 1'b1;
	default:	deco.st = 1'b0;
	endcase

	// Byte size when there is no access at all
	case (op)
	decodePkg::LDW, decodePkg::LDWU, decodePkg::STW:	deco.memsz = decodePkg::wyde;
	decodePkg::LDT, decodePkg::STT:	deco.memsz = decodePkg::tetra;
	default:	deco.memsz = decodePkg::byt;
	endcase

	// ==========================================================
	// Multiply and divide
	// ==========================================================
	deco.mul = 1'b0;
	deco.mulu = 1'b0;
	deco.div = 1'b0;
	deco.divu = 1'b0;
	case (op)
	decodePkg::R2:
		case (ir.r2.func)
		decodePkg::MUL:	deco.mul = 1'b1;
		decodePkg::MULU:	deco.mulu = 1'b1;
		decodePkg::DIV:	deco.div = 1'b1;
		decodePkg::DIVU:	deco.divu = 1'b1;
		default:	;
		endcase
	decodePkg::MULI:	deco.mul = 1'b1;
	decodePkg::MULUI:	deco.mulu = 1'b1;
	decodePkg::DIVI:	deco.div = 1'b1;
	default:	;
	endcase
	deco.multiCycle = deco.mul | deco.mulu | deco.div | deco.divu | deco.ld | deco.st;

	// ==========================================================
	// Jumps and branches
	// ==========================================================
	deco.jmp = op == decodePkg::JMP;
	case (op)
	decodePkg::JEQ, decodePkg::JNE, decodePkg::JLT, decodePkg::JGE:	deco.jxx = 1'b1;
	default:	deco.jxx = 1'b0;
	endcase

	// Word aligned targets
	if (deco.jmp)
		deco.jmptgt = {{4{ir.jmp.tgt26[25]}}, ir.jmp.tgt26, 2'b00};
	else if (deco.jxx)
		deco.jmptgt = {{19{ir.jxx.disp11[10]}}, ir.jxx.disp11, 2'b00};
	else
		deco.jmptgt = 32'd0;

	// ==========================================================
	// Immediate constant
	// ==========================================================
	hasImm = 1'b1;
	case (op)
	decodePkg::ADDI, decodePkg::MULI, decodePkg::DIVI:
		imm = {{16{ir.ri.imm16[15]}}, ir.ri.imm16};
	// Pad with ones so the upper bits survive the AND
	decodePkg::ANDI:	imm = {16'hFFFF, ir.ri.imm16};
	decodePkg::ORI, decodePkg::XORI, decodePkg::MULUI:
		imm = {16'h0000, ir.ri.imm16};
	decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU, decodePkg::LDT,
	decodePkg::STB, decodePkg::STW, decodePkg::STT:
		imm = {{16{ir.mem.disp16[15]}}, ir.mem.disp16};
	default:
		begin
			imm = 32'd0;
			hasImm = 1'b0;
		end
	endcase
	if (pair.prefixed && hasImm)
		imm = {pair.xir.exi.hi16, imm[15:0]};
	deco.imm = imm;
	deco.prefixed = pair.prefixed;
end

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
// Output pipeline register for the decode record
// One entry with valid/ready handshake, streams a record per cycle
`default_nettype none
`timescale 1ns/100ps

module decodeStage
(
	input  logic clk,
	input  logic rstN,
	input  logic pairValid,
	input  decodePkg::decodeOutT deco,
	input  logic decReady,
	output logic pairReady,
	output logic decValid,
	output decodePkg::decodeOutT decOut
);

// Accept when empty or when the current record leaves this cycle
assign pairReady = !decValid || decReady;

always_ff @(posedge clk)
begin
	if (!rstN)
		decValid <= 1'b0;
	else if (pairReady)
		decValid <= pairValid;
end

always_ff @(posedge clk)
begin
	if (pairValid && pairReady)
		decOut <= deco;
end

// ==========================================================
// Handshake rules
// ==========================================================
// A stalled record is held until issue takes it
assert property (@(posedge clk) disable iff (!rstN)
	decValid && !decReady |=> decValid && $stable(decOut))
	else $error("decOut changed while stalled");

endmodule

`default_nettype wire

// File: rtl/decodeTop.sv
// Decode stage top level, APB loading on one side and issue handshake on the other
// Queue feeds the prefix merger, the decoder and the output register
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module decodeTop
(
	input  logic clk,
	input  logic rstN,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic decValid,
	output decodePkg::decodeOutT decOut,
	input  logic decReady
);

logic headValid;
logic headPop;
logic prefixHeld;
logic pairValid;
logic pairReady;
decodePkg::instrT headInstr;
decodePkg::instrPairT pair;
decodePkg::decodeOutT deco;

instrQueue queue_i (.clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
	.pready, .pslverr, .headValid, .headInstr, .headPop, .prefixHeld);

prefixMerge merge_i (.clk, .rstN, .headValid, .headInstr, .pairReady, .headPop,
	.pairValid, .pair, .prefixHeld);

instrDecoder decoder_i (.pair, .deco);

decodeStage stage_i (.clk, .rstN, .pairValid, .deco, .decReady, .pairReady,
	.decValid, .decOut);

endmodule

`default_nettype wire

// File: verification/decodeTb.sv
// Testbench for the decode stage top level
// Loads words over APB, checks status, errors and every record with concurrent assertions
`default_nettype none
`timescale 1ns/100ps
`include "decode_settings.svh"

module decodeTb;

localparam int NUM_RANDOM = 300;

logic clk;
logic rstN;
logic [`APB_ADDR_W-1:0] paddr;
logic psel;
logic penable;
logic pwrite;
logic [31:0] pwdata;
logic [31:0] prdata;
logic pready;
logic pslverr;
logic decValid;
logic decReady;
decodePkg::decodeOutT decOut;

// Expected side, driven by the stimulus and the record monitor
decodePkg::decodeOutT expQ [$];
decodePkg::decodeOutT expHead;
decodePkg::decodeOutT prevOut;
logic expAvail;
logic expErr;
logic checkRead;
logic [31:0] expRdata;
logic [31:0] heldPrefix;
logic modelHeld;
logic randomReady;
logic [31:0] stimState;
logic [31:0] readyState;
int wordsSent;
int cycles;

decodePkg::opcodeE opList [22] = '{decodePkg::NOP, decodePkg::R2, decodePkg::ADDI,
	decodePkg::ANDI, decodePkg::ORI, decodePkg::XORI, decodePkg::MULI, decodePkg::MULUI,
	decodePkg::DIVI, decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU,
	decodePkg::LDT, decodePkg::STB, decodePkg::STW, decodePkg::STT, decodePkg::JMP,
	decodePkg::JEQ, decodePkg::JNE, decodePkg::JLT, decodePkg::JGE};
decodePkg::funcE funcList [8] = '{decodePkg::ADD, decodePkg::SUB, decodePkg::AND,
	decodePkg::OR, decodePkg::MUL, decodePkg::MULU, decodePkg::DIV, decodePkg::DIVU};

decodeTop dut_i (.clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
	.pready, .pslverr, .decValid, .decOut, .decReady);

initial
begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

task automatic failRun(input string why);
	$display("%s", why);
	$display("RESULT: FAIL");
	$fatal(1);
endtask

function automatic logic [31:0] xorshift(input logic [31:0] s);
	logic [31:0] v;
	v = s;
	v ^= v << 13;
	v ^= v >> 17;
	v ^= v << 5;
	return v;
endfunction

function automatic logic [31:0] nextRand();
	stimState = xorshift(stimState);
	return stimState;
endfunction

// ==========================================================
// Reference model, built from the decode rules
// ==========================================================
function automatic decodePkg::decodeOutT expectRecord(input logic [31:0] w,
	input logic [31:0] x, input logic pre);
	decodePkg::decodeOutT r;
	decodePkg::opcodeE op;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic immOp;
	logic [15:0] lo;
	op = decodePkg::opcodeE'(w[31:26]);
	lo = w[15:0];
	r = '0;
	isLoad = op inside {decodePkg::LDB, decodePkg::LDBU, decodePkg::LDW, decodePkg::LDWU,
		decodePkg::LDT};
	isStore = op inside {decodePkg::STB, decodePkg::STW, decodePkg::STT};
	isBranch = op inside {decodePkg::JEQ, decodePkg::JNE, decodePkg::JLT, decodePkg::JGE};
	immOp = isLoad || isStore || op inside {decodePkg::ADDI, decodePkg::ANDI, decodePkg::ORI,
		decodePkg::XORI, decodePkg::MULI, decodePkg::MULUI, decodePkg::DIVI};
	r.Ra = isBranch ? w[25:21] : w[20:16];
	r.Rb = isBranch ? w[20:16] : w[15:11];
	r.Rc = isStore ? w[25:21] : 5'd0;
	r.Rt = (isStore || isBranch || op == decodePkg::JMP) ? 5'd0 : w[25:21];
	r.rfwr = isLoad || op inside {decodePkg::R2, decodePkg::ADDI, decodePkg::ANDI,
		decodePkg::ORI, decodePkg::XORI, decodePkg::MULI, decodePkg::MULUI, decodePkg::DIVI};
	r.ld = isLoad;
	r.ldz = op inside {decodePkg::LDBU, decodePkg::LDWU};
	r.st = isStore;
	if (op inside {decodePkg::LDW, decodePkg::LDWU, decodePkg::STW})
		r.memsz = decodePkg::wyde;
	else if (op inside {decodePkg::LDT, decodePkg::STT})
		r.memsz = decodePkg::tetra;
	r.mul = op == decodePkg::MULI || (op == decodePkg::R2 && w[5:0] == decodePkg::MUL);
	r.mulu = op == decodePkg::MULUI || (op == decodePkg::R2 && w[5:0] == decodePkg::MULU);
	r.div = op == decodePkg::DIVI || (op == decodePkg::R2 && w[5:0] == decodePkg::DIV);
	r.divu = op == decodePkg::R2 && w[5:0] == decodePkg::DIVU;
	r.multiCycle = r.mul || r.mulu || r.div || r.divu || isLoad || isStore;
	r.jmp = op == decodePkg::JMP;
	r.jxx = isBranch;
	if (r.jmp)
		r.jmptgt = {{4{w[25]}}, w[25:0], 2'b00};
	else if (isBranch)
		r.jmptgt = {{19{w[10]}}, w[10:0], 2'b00};
	// Padding by opcode class, a prefix replaces the upper half
	if (op inside {decodePkg::ADDI, decodePkg::MULI, decodePkg::DIVI} || isLoad || isStore)
		r.imm = {{16{lo[15]}}, lo};
	else if (op == decodePkg::ANDI)
		r.imm = {16'hFFFF, lo};
	else if (op inside {decodePkg::ORI, decodePkg::XORI, decodePkg::MULUI})
		r.imm = {16'h0000, lo};
	if (pre && immOp)
		r.imm = {x[15:0], lo};
	r.prefixed = pre;
	return r;
endfunction

task automatic refreshHead();
	expAvail = expQ.size() != 0;
	if (expAvail)
		expHead = expQ[0];
endtask

task automatic modelWord(input logic [31:0] w);
	if (w[31:26] == decodePkg::EXI)
	begin
		heldPrefix = w;
		modelHeld = 1'b1;
	end
	else
	begin
		expQ.push_back(expectRecord(w, heldPrefix, modelHeld));
		modelHeld = 1'b0;
		refreshHead();
	end
endtask

function automatic logic [31:0] randomInstr();
	logic [31:0] w;
	decodePkg::opcodeE op;
	w = nextRand();
	op = opList[nextRand() % 22];
	w[31:26] = op;
	if (op == decodePkg::R2)
		w[5:0] = funcList[nextRand() % 8];
	return w;
endfunction

function automatic logic [31:0] randomPrefix();
	logic [31:0] w;
	w = nextRand();
	w[31:26] = decodePkg::EXI;
	return w;
endfunction

// ==========================================================
// APB driver
// ==========================================================
task automatic apbWrite(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
	input logic errExp);
	@(negedge clk);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b1;
	paddr = addr;
	pwdata = data;
	expErr = errExp;
	if (addr == `REG_INSTR && !errExp)
	begin
		modelWord(data);
		wordsSent++;
	end
	@(negedge clk);
	penable = 1'b1;
	@(negedge clk);
	psel = 1'b0;
	penable = 1'b0;
	expErr = 1'b0;
endtask

task automatic apbRead(input logic [`APB_ADDR_W-1:0] addr, input logic check,
	input logic [31:0] expected, input logic errExp, output logic [31:0] data);
	@(negedge clk);
	psel = 1'b1;
	penable = 1'b0;
	pwrite = 1'b0;
	paddr = addr;
	checkRead = check;
	expRdata = expected;
	expErr = errExp;
	@(negedge clk);
	penable = 1'b1;
	#1 data = prdata;
	@(negedge clk);
	psel = 1'b0;
	penable = 1'b0;
	checkRead = 1'b0;
	expErr = 1'b0;
endtask

// Wait until the queue has room, the fill level only drops meanwhile
task automatic waitForRoom();
	logic [31:0] st;
	st = 32'(`QUEUE_DEPTH);
	while (st[3:0] >= `QUEUE_DEPTH)
		apbRead(`REG_STATUS, 1'b0, 32'd0, 1'b0, st);
endtask

// ==========================================================
// Checks
// ==========================================================
always @(posedge clk)
begin
	prevOut <= decOut;
	if (rstN && decValid && decReady && expQ.size() != 0)
	begin
		void'(expQ.pop_front());
		refreshHead();
	end
end

assert property (@(posedge clk) !rstN |=> !decValid)
	else failRun("decValid high right after reset");
assert property (@(posedge clk) psel |-> pready)
	else failRun($sformatf("ERROR %0t pready expected 1 got %b", $time, $sampled(pready)));
assert property (@(posedge clk) pslverr == (psel && penable && expErr))
	else failRun($sformatf("ERROR %0t pslverr expected %b got %b", $time,
		$sampled(psel && penable && expErr), $sampled(pslverr)));
assert property (@(posedge clk) psel && penable && !pwrite && checkRead |-> prdata == expRdata)
	else failRun($sformatf("ERROR %0t prdata expected %h got %h", $time,
		$sampled(expRdata), $sampled(prdata)));
assert property (@(posedge clk) disable iff (!rstN) decValid |-> expAvail)
	else failRun("decValid high with no instruction left to decode");
assert property (@(posedge clk) disable iff (!rstN) decValid && decReady |-> decOut == expHead)
	else failRun($sformatf("ERROR %0t decOut expected %h got %h", $time,
		$sampled(expHead), $sampled(decOut)));
assert property (@(posedge clk) disable iff (!rstN)
	decValid && !decReady |=> decValid && decOut == prevOut)
	else failRun($sformatf("ERROR %0t decOut expected %h got %h", $time,
		$sampled(prevOut), $sampled(decOut)));

// Issue side readiness, random once the stall tests are done
always @(negedge clk)
begin
	readyState = xorshift(readyState);
	decReady = randomReady & readyState[4];
end

initial
begin
	cycles = 0;
	while (cycles <= 40 * wordsSent + 200)
	begin
		@(posedge clk);
		cycles++;
	end
	failRun("Timeout, records stopped arriving from the DUT");
end

// ==========================================================
// Stimulus
// ==========================================================
initial
begin
	logic [31:0] rd;
	int nPre;
	rstN = 1'b0;
	paddr = '0;
	psel = 1'b0;
	penable = 1'b0;
	pwrite = 1'b0;
	pwdata = '0;
	decReady = 1'b0;
	expErr = 1'b0;
	checkRead = 1'b0;
	expRdata = '0;
	expAvail = 1'b0;
	expHead = '0;
	heldPrefix = '0;
	modelHeld = 1'b0;
	randomReady = 1'b0;
	stimState = 32'd51013;
	readyState = ~32'd51013;
	wordsSent = 0;
	repeat (3) @(negedge clk);
	rstN = 1'b1;

	// Empty queue and no prefix after reset
	apbRead(`REG_STATUS, 1'b1, 32'h0, 1'b0, rd);
	apbWrite(`REG_INSTR, randomPrefix(), 1'b0);
	apbRead(`REG_STATUS, 1'b1, 32'h100, 1'b0, rd);
	apbWrite(`REG_INSTR, randomInstr(), 1'b0);
	while (!decValid)
		@(negedge clk);
	apbRead(`REG_STATUS, 1'b1, 32'h0, 1'b0, rd);

	// Stage stalled, so the queue fills word by word
	for (int k = 1; k <= `QUEUE_DEPTH; k++)
	begin
		apbWrite(`REG_INSTR, randomInstr(), 1'b0);
		apbRead(`REG_STATUS, 1'b1, 32'(k), 1'b0, rd);
	end
	apbWrite(`REG_INSTR, randomInstr(), 1'b1);
	apbWrite(`REG_STATUS, 32'h1234, 1'b1);
	apbWrite(4'h8, 32'h5678, 1'b1);
	apbRead(4'hC, 1'b0, 32'h0, 1'b1, rd);

	// Random words with single and double prefixes under random back-pressure
	randomReady = 1'b1;
	for (int i = 0; i < NUM_RANDOM; i++)
	begin
		nPre = nextRand() % 8;
		nPre = (nPre < 6) ? 0 : nPre - 5;
		for (int p = 0; p < nPre; p++)
		begin
			waitForRoom();
			apbWrite(`REG_INSTR, randomPrefix(), 1'b0);
		end
		waitForRoom();
		apbWrite(`REG_INSTR, randomInstr(), 1'b0);
	end

	while (expQ.size() != 0)
		@(negedge clk);
	repeat (20) @(negedge clk);
	$display("RESULT: PASS");
	$finish;
end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/decodePkg.sv
rtl/instrQueue.sv
rtl/prefixMerge.sv
rtl/instrDecoder.sv
rtl/decodeStage.sv
rtl/decodeTop.sv
verification/decodeTb.sv
